// File: soc_pkg.sv
package soc_pkg;

  // bus widths
  typedef logic [31:0] word_t;  // data word
  typedef logic [31:0] addr_t;  // byte address
  typedef logic [3:0]  sel_t;   // one enable per byte lane

  // address split into region and offset
  typedef logic [3:0]  region_t;  // addr bits 31..28
  typedef logic [27:0] offset_t;  // addr bits 27..0

  // peripheral values
  typedef logic [7:0]  led_t;
  typedef logic [1:0]  key_t;

  // which target owes the response
  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_MEM,
    TGT_LED,
    TGT_KEY
  } target_e;

  // address map
  localparam region_t REGION_MEM = 4'h0;  // on-chip word memory
  localparam region_t REGION_IO  = 4'h8;  // peripheral registers

  localparam offset_t LED_OFFSET = 28'h000_0000;
  localparam offset_t KEY_OFFSET = 28'h000_0004;

endpackage

// File: bus_decode.sv
`timescale 1ns/1ps

module bus_decode #(
  parameter int MEM_ADDR_BITS = 10
) (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             cyc_i,
  input  logic             stb_i,
  input  soc_pkg::addr_t   adr_i,
  output logic             mem_req_o,
  output logic             led_req_o,
  output logic             key_req_o,
  output soc_pkg::target_e resp_tgt_o,
  output logic             resp_pending_o
);

  logic             req;
  soc_pkg::region_t region;
  soc_pkg::offset_t offset;
  soc_pkg::target_e tgt;

  assign req    = cyc_i & stb_i;  // no stall, every strobe is taken
  assign region = adr_i[31:28];
  assign offset = adr_i[27:0];

  // memory only covers the low 2**MEM_ADDR_BITS words of its region
  always_comb
  begin
    tgt = soc_pkg::TGT_NONE;
    if (region == soc_pkg::REGION_MEM && (offset >> (MEM_ADDR_BITS + 2)) == '0)
      tgt = soc_pkg::TGT_MEM;
    else if (region == soc_pkg::REGION_IO && offset == soc_pkg::LED_OFFSET)
      tgt = soc_pkg::TGT_LED;
    else if (region == soc_pkg::REGION_IO && offset == soc_pkg::KEY_OFFSET)
      tgt = soc_pkg::TGT_KEY;
  end

  assign mem_req_o = req && (tgt == soc_pkg::TGT_MEM);
  assign led_req_o = req && (tgt == soc_pkg::TGT_LED);
  assign key_req_o = req && (tgt == soc_pkg::TGT_KEY);

  // remember who answers in the next cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      resp_tgt_o     <= soc_pkg::TGT_NONE;
      resp_pending_o <= 1'b0;
    end
    else
    begin
      resp_pending_o <= req;
      if (req)
        resp_tgt_o <= tgt;
      else
        resp_tgt_o <= soc_pkg::TGT_NONE;  // idle cycle, no owner
    end
  end

endmodule

// File: data_mem.sv
`timescale 1ns/1ps

module data_mem #(
  parameter int MEM_ADDR_BITS = 10
) (
  input  logic           clk,
  input  logic           rst_n_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t adr_i,
  input  soc_pkg::sel_t  sel_i,
  input  soc_pkg::word_t dat_i,
  output logic           ack_o,
  output soc_pkg::word_t dat_o
);

  localparam int DEPTH = 2 ** MEM_ADDR_BITS;

  soc_pkg::word_t           mem [DEPTH];
  logic [MEM_ADDR_BITS-1:0] word_idx;
  soc_pkg::word_t           rdata_q;
  logic                     ack_q;

  // word addressing, byte offset bits dropped
  assign word_idx = adr_i[MEM_ADDR_BITS+1:2];

  // byte lane writes
  always_ff @(posedge clk)
  begin
    if (req_i && we_i)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (sel_i[b])
          mem[word_idx][b*8 +: 8] <= dat_i[b*8 +: 8];
      end
    end
  end

  // read word registered at the request edge
  always_ff @(posedge clk)
  begin
    if (req_i && !we_i)
      rdata_q <= mem[word_idx];
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= req_i;  // single cycle answer
  end

  assign ack_o = ack_q;
  assign dat_o = rdata_q;

endmodule

// File: led_regs.sv
`timescale 1ns/1ps

module led_regs (
  input  logic           clk,
  input  logic           rst_n_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::sel_t  sel_i,
  input  soc_pkg::word_t dat_i,
  output logic           ack_o,
  output soc_pkg::word_t dat_o,
  output soc_pkg::led_t  led_o
);

  soc_pkg::led_t led_q;
  logic          ack_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      led_q <= '0;  // leds dark after reset
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= req_i;
      // only byte lane 0 holds the led bits
      if (req_i && we_i && sel_i[0])
        led_q <= dat_i[7:0];
    end
  end

  assign ack_o = ack_q;
  assign dat_o = soc_pkg::word_t'(led_q);  // zero-extended
  assign led_o = led_q;

endmodule

// File: key_regs.sv
`timescale 1ns/1ps

module key_regs (
  input  logic           clk,
  input  logic           rst_n_i,
  input  logic           req_i,
  input  soc_pkg::key_t  key_i,
  output logic           ack_o,
  output soc_pkg::word_t dat_o
);

  soc_pkg::key_t  key_meta;
  soc_pkg::key_t  key_sync;
  soc_pkg::word_t rdata_q;
  logic           ack_q;

  // two flop synchronizer for the board keys
  always_ff @(posedge clk)
  begin
    key_meta <= key_i;
    key_sync <= key_meta;
  end

  // reads and writes both answer, writes change nothing
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= req_i;
  end

  always_ff @(posedge clk)
  begin
    if (req_i)
      rdata_q <= soc_pkg::word_t'(key_sync);  // keys in the low bits
  end

  assign ack_o = ack_q;
  assign dat_o = rdata_q;

endmodule

// File: bus_response.sv
`timescale 1ns/1ps

module bus_response (
  input  soc_pkg::target_e resp_tgt_i,
  input  logic             resp_pending_i,
  input  logic             mem_ack_i,
  input  logic             led_ack_i,
  input  logic             key_ack_i,
  input  soc_pkg::word_t   mem_dat_i,
  input  soc_pkg::word_t   led_dat_i,
  input  soc_pkg::word_t   key_dat_i,
  output logic             ack_o,
  output logic             err_o,
  output soc_pkg::word_t   dat_o
);

  // at most one target acks in any cycle
  assign ack_o = mem_ack_i | led_ack_i | key_ack_i;

  // a taken request that nobody owns
  assign err_o = resp_pending_i && (resp_tgt_i == soc_pkg::TGT_NONE);

  always_comb
  begin
    case (resp_tgt_i)
      soc_pkg::TGT_MEM: dat_o = mem_dat_i;
      soc_pkg::TGT_LED: dat_o = led_dat_i;
      soc_pkg::TGT_KEY: dat_o = key_dat_i;
      default:          dat_o = '0;  // idle or unmapped
    endcase
  end

endmodule

// File: soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top #(
  parameter int MEM_ADDR_BITS = 10
) (
  input  logic           clk,
  input  logic           rst_n_i,
  input  logic           bus_cyc_i,
  input  logic           bus_stb_i,
  input  logic           bus_we_i,
  input  soc_pkg::addr_t bus_adr_i,
  input  soc_pkg::sel_t  bus_sel_i,
  input  soc_pkg::word_t bus_dat_i,
  input  soc_pkg::key_t  key_i,
  output logic           bus_ack_o,
  output logic           bus_err_o,
  output soc_pkg::word_t bus_dat_o,
  output soc_pkg::led_t  led_o
);

  logic             mem_req;
  logic             led_req;
  logic             key_req;
  soc_pkg::target_e resp_tgt;
  logic             resp_pending;
  logic             mem_ack;
  logic             led_ack;
  logic             key_ack;
  soc_pkg::word_t   mem_dat;
  soc_pkg::word_t   led_dat;
  soc_pkg::word_t   key_dat;

  bus_decode #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) u_decode (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .cyc_i          (bus_cyc_i),
    .stb_i          (bus_stb_i),
    .adr_i          (bus_adr_i),
    .mem_req_o      (mem_req),
    .led_req_o      (led_req),
    .key_req_o      (key_req),
    .resp_tgt_o     (resp_tgt),
    .resp_pending_o (resp_pending)
  );

  data_mem #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) u_mem (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (mem_req),
    .we_i    (bus_we_i),
    .adr_i   (bus_adr_i),
    .sel_i   (bus_sel_i),
    .dat_i   (bus_dat_i),
    .ack_o   (mem_ack),
    .dat_o   (mem_dat)
  );

  led_regs u_led (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (led_req),
    .we_i    (bus_we_i),
    .sel_i   (bus_sel_i),
    .dat_i   (bus_dat_i),
    .ack_o   (led_ack),
    .dat_o   (led_dat),
    .led_o   (led_o)
  );

  key_regs u_key (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (key_req),
    .key_i   (key_i),
    .ack_o   (key_ack),
    .dat_o   (key_dat)
  );

  bus_response u_resp (
    .resp_tgt_i     (resp_tgt),
    .resp_pending_i (resp_pending),
    .mem_ack_i      (mem_ack),
    .led_ack_i      (led_ack),
    .key_ack_i      (key_ack),
    .mem_dat_i      (mem_dat),
    .led_dat_i      (led_dat),
    .key_dat_i      (key_dat),
    .ack_o          (bus_ack_o),
    .err_o          (bus_err_o),
    .dat_o          (bus_dat_o)
  );

endmodule

// File: tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;

  localparam int MEM_ADDR_BITS = 10;  // DUT default
  localparam int N_WORDS       = 16;
  localparam soc_pkg::addr_t LED_ADDR = {soc_pkg::REGION_IO, soc_pkg::LED_OFFSET};
  localparam soc_pkg::addr_t KEY_ADDR = {soc_pkg::REGION_IO, soc_pkg::KEY_OFFSET};

  typedef struct packed {
    logic           ack;
    logic           err;
    logic           chk;  // read data is compared
    soc_pkg::word_t dat;
  } resp_t;

  logic           clk;
  logic           rst_n_i;
  logic           bus_cyc_i;
  logic           bus_stb_i;
  logic           bus_we_i;
  soc_pkg::addr_t bus_adr_i;
  soc_pkg::sel_t  bus_sel_i;
  soc_pkg::word_t bus_dat_i;
  soc_pkg::key_t  key_i;
  logic           bus_ack_o;
  logic           bus_err_o;
  soc_pkg::word_t bus_dat_o;
  soc_pkg::led_t  led_o;

  soc_pkg::word_t shadow_mem [2**MEM_ADDR_BITS];  // unwritten words stay x like the DUT
  soc_pkg::led_t  led_model = '0;
  logic [31:0]    rng_state = 32'd73693;
  string          test_name = "reset";
  string          exp_name  = "reset";
  resp_t          exp_resp;
  logic           resp_due  = 1'b0;
  logic           exp_ack;
  logic           exp_err;
  soc_pkg::addr_t mem_addrs [N_WORDS];

  soc_bus_top DUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // random word in memory, byte offset bits random too
  function automatic soc_pkg::addr_t mem_addr(input logic [31:0] r);
    soc_pkg::addr_t a;
    a = '0;
    a[MEM_ADDR_BITS+1:0] = r[MEM_ADDR_BITS+1:0];
    return a;
  endfunction

  // expected answer of one request, updates the model state
  function automatic resp_t ref_response(input logic we, input soc_pkg::addr_t adr,
                                         input soc_pkg::sel_t sel, input soc_pkg::word_t dat,
                                         input soc_pkg::key_t keys);
    resp_t          r;
    int             idx;
    soc_pkg::word_t w;
    r = '0;
    if (adr[31:28] == soc_pkg::REGION_MEM && adr[27:MEM_ADDR_BITS+2] == '0)
    begin
      idx   = adr[MEM_ADDR_BITS+1:2];
      w     = shadow_mem[idx];
      r.ack = 1'b1;
      if (we)
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (sel[b])
            w[b*8 +: 8] = dat[b*8 +: 8];
        end
        shadow_mem[idx] = w;
      end
      else
      begin
        r.chk = 1'b1;
        r.dat = w;
      end
    end
    else if (adr == LED_ADDR)
    begin
      r.ack = 1'b1;
      if (we && sel[0])
        led_model = dat[7:0];
      r.chk = !we;
      r.dat = {24'h0, led_model};
    end
    else if (adr == KEY_ADDR)
    begin
      r.ack = 1'b1;
      r.chk = !we;  // writes are ignored
      r.dat = {30'h0, keys};
    end
    else
    begin
      r.err = 1'b1;
      r.chk = 1'b1;  // no target, data reads as zero
    end
    return r;
  endfunction

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic issue_req(input logic we, input soc_pkg::addr_t adr,
                           input soc_pkg::sel_t sel, input soc_pkg::word_t dat);
    bus_cyc_i = 1'b1;
    bus_stb_i = 1'b1;
    bus_we_i  = we;
    bus_adr_i = adr;
    bus_sel_i = sel;
    bus_dat_i = dat;
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycle();
    bus_cyc_i = 1'b0;
    bus_stb_i = 1'b0;
    @(posedge clk);
    #1;
  endtask

  // every edge checks the answer owed by the request of the previous edge
  always @(posedge clk)
  begin
    if (rst_n_i)
    begin
      exp_ack = resp_due && exp_resp.ack;
      exp_err = resp_due && exp_resp.err;
      if (!resp_due)
        exp_name = test_name;
      assert (bus_ack_o === exp_ack)
      else
      begin
        $display("error %s: ack expected %0b actual %0b", exp_name, exp_ack, bus_ack_o);
        abort_run();
      end
      assert (bus_err_o === exp_err)
      else
      begin
        $display("error %s: err expected %0b actual %0b", exp_name, exp_err, bus_err_o);
        abort_run();
      end
      if (resp_due && exp_resp.chk)
      begin
        assert (bus_dat_o === exp_resp.dat)
        else
        begin
          $display("error %s: data expected %08h actual %08h", exp_name, exp_resp.dat,
                   bus_dat_o);
          abort_run();
        end
      end
      assert (led_o === led_model)
      else
      begin
        $display("error %s: led expected %02h actual %02h", exp_name, led_model, led_o);
        abort_run();
      end
      resp_due = bus_cyc_i && bus_stb_i;  // request taken at this edge
      if (resp_due)
      begin
        exp_resp = ref_response(bus_we_i, bus_adr_i, bus_sel_i, bus_dat_i, key_i);
        exp_name = test_name;
      end
    end
  end

  initial
  begin
    logic [31:0] r;
    int          wait_cnt;
    rst_n_i   = 1'b0;
    bus_cyc_i = 1'b0;
    bus_stb_i = 1'b0;
    bus_we_i  = 1'b0;
    bus_adr_i = '0;
    bus_sel_i = '0;
    bus_dat_i = '0;
    key_i     = 2'b00;
    repeat (3) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    assert (bus_ack_o === 1'b0 && bus_err_o === 1'b0 && led_o === 8'h00)
    else
    begin
      $display("error reset: ack/err/led expected 0/0/00 actual %0b/%0b/%02h",
               bus_ack_o, bus_err_o, led_o);
      abort_run();
    end

    test_name = "mem_full_word";
    for (int i = 0; i < N_WORDS; i++)
    begin
      mem_addrs[i] = mem_addr(next_rand());
      issue_req(1'b1, mem_addrs[i], 4'hf, next_rand());
    end
    for (int i = 0; i < N_WORDS; i++)
      issue_req(1'b0, mem_addrs[i], 4'h0, next_rand());

    test_name = "mem_partial";
    for (int i = 0; i < N_WORDS; i++)
    begin
      issue_req(1'b1, mem_addrs[i], soc_pkg::sel_t'(next_rand()), next_rand());
      issue_req(1'b0, mem_addrs[i], 4'h0, '0);  // sees the merged word
    end

    test_name = "led";
    issue_req(1'b1, LED_ADDR, 4'b1110, 32'hffff_ffff);  // lane 0 off, no change
    issue_req(1'b0, LED_ADDR, 4'h0, '0);
    for (int i = 0; i < 6; i++)
    begin
      issue_req(1'b1, LED_ADDR, soc_pkg::sel_t'(next_rand()), next_rand());
      issue_req(1'b0, LED_ADDR, 4'h0, '0);
    end

    test_name = "key";
    key_i = 2'b10;
    repeat (4) idle_cycle();  // let the synchronizer settle
    issue_req(1'b0, KEY_ADDR, 4'h0, '0);
    issue_req(1'b1, KEY_ADDR, 4'hf, next_rand());
    issue_req(1'b0, KEY_ADDR, 4'h0, '0);
    key_i = 2'b01;
    repeat (4) idle_cycle();
    issue_req(1'b0, KEY_ADDR, 4'h0, '0);

    test_name = "unmapped_region";
    // offset inside the memory range, only the region makes it unmapped
    issue_req(1'b1, {4'h3, mem_addrs[1][27:0]}, 4'hf, next_rand());
    issue_req(1'b0, {4'hc, mem_addrs[1][27:0]}, 4'h0, '0);
    issue_req(1'b0, mem_addrs[1], 4'h0, '0);  // memory word unchanged
    test_name = "unmapped_mem_range";
    issue_req(1'b1, mem_addrs[0] | (32'h1 << (MEM_ADDR_BITS + 2 + (next_rand() % 16))),
              4'hf, next_rand());
    issue_req(1'b0, mem_addrs[0], 4'h0, '0);  // aliased word unchanged
    test_name = "unmapped_io";
    r = next_rand();
    issue_req(1'b1, {soc_pkg::REGION_IO, r[27:0] | 28'h8}, 4'hf, next_rand());
    issue_req(1'b0, {soc_pkg::REGION_IO, r[27:0] | 28'h8}, 4'h0, '0);
    issue_req(1'b0, LED_ADDR, 4'h0, '0);
    bus_cyc_i = 1'b0;
    bus_stb_i = 1'b0;

    // last request still owes its answer
    wait_cnt = 0;
    while (resp_due && wait_cnt < 8)
    begin
      @(posedge clk);
      #1;
      wait_cnt++;
    end
    if (resp_due)
    begin
      $display("timeout while waiting for the last response to be checked");
      abort_run();
    end
    else
    begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// File: list.f
soc_pkg.sv
bus_decode.sv
data_mem.sv
led_regs.sv
key_regs.sv
bus_response.sv
soc_bus_top.sv
tb_soc_bus.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - soc_pkg.sv
  - bus_decode.sv
  - data_mem.sv
  - led_regs.sv
  - key_regs.sv
  - bus_response.sv
  - soc_bus_top.sv
  - target: test
    files:
      - tb_soc_bus.sv
